// File: src/ppu_pkg.sv
package ppu_pkg;

    // cpu-visible register select, follows the low address bits
    typedef enum logic [2:0] {
        REG_CTRL   = 3'd0,
        REG_MASK   = 3'd1,
        REG_STATUS = 3'd2,
        REG_ADDR   = 3'd6,
        REG_DATA   = 3'd7
    } reg_sel_t;

    // vertical and horizontal raster phases
    typedef enum logic [1:0] {
        PRE_LINE,
        VISIBLE_LINE,
        POST_LINE,
        VBLANK_LINE
    } vs_state_t;

    typedef enum logic [1:0] {
        ACTIVE_DOTS,
        HBLANK_DOTS
    } hs_state_t;

    typedef logic [4:0] pal_idx_t;
    typedef logic [5:0] colour_t;

    // register bit positions
    localparam int CTRL_NMI_BIT      = 7;
    localparam int CTRL_INC32_BIT    = 2;
    localparam int MASK_GREY_BIT     = 0;
    localparam int STATUS_VBLANK_BIT = 7;

    // start of palette space in the 14-bit ppu address map
    localparam logic [13:0] PAL_BASE = 14'h3F00;

    // full ntsc frame
    localparam int DEF_DOTS_PER_LINE   = 341;
    localparam int DEF_LINES_PER_FRAME = 262;
    localparam int DEF_VISIBLE_DOTS    = 256;
    localparam int DEF_VISIBLE_LINES   = 240;

endpackage

// File: src/dot_if.sv
`timescale 1ns/10ps

interface dot_if;

    // raster position
    logic [8:0] dot_x;
    logic [8:0] dot_y;
    logic       visible;

    // single-cycle frame events
    logic       vblank_set;
    logic       vblank_clr;

    modport timing (output dot_x, output dot_y, output visible,
                    output vblank_set, output vblank_clr);

    modport events (input vblank_set, input vblank_clr);

    modport raster (input dot_x, input dot_y, input visible);

endinterface

// File: src/pal_if.sv
`timescale 1ns/10ps

interface pal_if
    import ppu_pkg::*;
;

    pal_idx_t addr;
    logic     we;
    colour_t  wdata;
    // combinational read of addr
    colour_t  rdata;

    modport master (output addr, output we, output wdata, input rdata);

    modport target (input addr, input we, input wdata, output rdata);

endinterface

// File: src/ppu_timing.sv
`timescale 1ns/10ps

module ppu_timing import ppu_pkg::*; #(
    parameter int DOTS_PER_LINE   = DEF_DOTS_PER_LINE,
    parameter int LINES_PER_FRAME = DEF_LINES_PER_FRAME,
    parameter int VISIBLE_DOTS    = DEF_VISIBLE_DOTS,
    parameter int VISIBLE_LINES   = DEF_VISIBLE_LINES
) (
    input  logic  clk,
    input  logic  rst_n,
    dot_if.timing dot
);

    localparam logic [8:0] LAST_DOT     = 9'(DOTS_PER_LINE - 1);
    localparam logic [8:0] LAST_ACTIVE  = 9'(VISIBLE_DOTS - 1);
    localparam logic [8:0] LAST_VISIBLE = 9'(VISIBLE_LINES - 1);
    localparam logic [8:0] FIRST_VBLANK = 9'(VISIBLE_LINES + 1);
    localparam logic [8:0] LAST_VBLANK  = 9'(LINES_PER_FRAME - 2);
    localparam logic [8:0] LAST_LINE    = 9'(LINES_PER_FRAME - 1);

    logic [8:0] col;
    logic [8:0] row;
    logic       line_end;

    hs_state_t hs_state, hs_next;
    vs_state_t vs_state, vs_next;

    assign line_end = (col == LAST_DOT);

    // dot and line counters, reset lands on the first visible line
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col <= '0;
            row <= '0;
        end else begin
            col <= line_end ? 9'd0 : col + 9'd1;
            if (line_end) begin
                row <= (row == LAST_LINE) ? 9'd0 : row + 9'd1;
            end
        end
    end

    always_comb begin
        hs_next = hs_state;
        case (hs_state)
            ACTIVE_DOTS: if (col == LAST_ACTIVE) hs_next = HBLANK_DOTS;
            HBLANK_DOTS: if (line_end) hs_next = ACTIVE_DOTS;
            default:     hs_next = ACTIVE_DOTS;
        endcase
    end

    // vertical phase only moves at the end of a line
    always_comb begin
        vs_next = vs_state;
        if (line_end) begin
            case (vs_state)
                VISIBLE_LINE: if (row == LAST_VISIBLE) vs_next = POST_LINE;
                POST_LINE:    vs_next = VBLANK_LINE;
                VBLANK_LINE:  if (row == LAST_VBLANK) vs_next = PRE_LINE;
                PRE_LINE:     vs_next = VISIBLE_LINE;
                default:      vs_next = VISIBLE_LINE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hs_state <= ACTIVE_DOTS;
            vs_state <= VISIBLE_LINE;
        end else begin
            hs_state <= hs_next;
            vs_state <= vs_next;
        end
    end

    assign dot.dot_x   = col;
    assign dot.dot_y   = row;
    assign dot.visible = (hs_state == ACTIVE_DOTS) && (vs_state == VISIBLE_LINE);

    // flag events on dot 1, first vblank line and pre-render line
    assign dot.vblank_set = (vs_state == VBLANK_LINE) && (row == FIRST_VBLANK) && (col == 9'd1);
    assign dot.vblank_clr = (vs_state == PRE_LINE) && (col == 9'd1);

endmodule

// File: src/ppu_regs.sv
`timescale 1ns/10ps

module ppu_regs import ppu_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,

    // cpu request channel
    input  logic       req_valid,
    input  logic       req_write,
    input  reg_sel_t   req_sel,
    input  logic [7:0] req_wdata,
    output logic       req_ready,

    // cpu read response channel
    output logic       resp_valid,
    output logic [7:0] resp_rdata,
    input  logic       resp_ready,

    output logic       nmi,
    output logic       mask_grey,

    dot_if.events      dot,
    pal_if.master      pal
);

    logic [7:0]  ppuctrl;
    logic [7:0]  ppumask;
    logic        vblank_flag;
    logic [13:0] vram_addr;
    // 0 = next PPUADDR write is the high byte
    logic        addr_toggle;

    logic        accept;
    logic        rd_accept;
    logic        status_rd;
    logic        pal_hit;
    logic [13:0] addr_step;
    logic [7:0]  rd_data;

    // hold off new requests while a response is stuck
    assign req_ready = !(resp_valid && !resp_ready);
    assign accept    = req_valid && req_ready;
    assign rd_accept = accept && !req_write;
    assign status_rd = rd_accept && (req_sel == REG_STATUS);

    assign pal_hit   = (vram_addr >= PAL_BASE);
    assign addr_step = ppuctrl[CTRL_INC32_BIT] ? 14'd32 : 14'd1;

    // palette port, write strobe in the accept cycle
    assign pal.addr  = vram_addr[4:0];
    assign pal.wdata = req_wdata[5:0];
    assign pal.we    = accept && req_write && (req_sel == REG_DATA) && pal_hit;

    always_comb begin
        rd_data = 8'h00;
        case (req_sel)
            REG_STATUS: rd_data[STATUS_VBLANK_BIT] = vblank_flag;
            REG_DATA:   if (pal_hit) rd_data = {2'b00, pal.rdata};
            default:    rd_data = 8'h00;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ppuctrl     <= '0;
            ppumask     <= '0;
            vram_addr   <= '0;
            addr_toggle <= 1'b0;
        end else if (accept) begin
            if (req_write) begin
                case (req_sel)
                    REG_CTRL: ppuctrl <= req_wdata;
                    REG_MASK: ppumask <= req_wdata;
                    REG_ADDR: begin
                        // high 6 bits first, then the low byte
                        if (!addr_toggle) begin
                            vram_addr[13:8] <= req_wdata[5:0];
                        end else begin
                            vram_addr[7:0] <= req_wdata;
                        end
                        addr_toggle <= !addr_toggle;
                    end
                    default: ;
                endcase
            end else if (req_sel == REG_STATUS) begin
                addr_toggle <= 1'b0;
            end
            // any PPUDATA access steps the address
            if (req_sel == REG_DATA) begin
                vram_addr <= vram_addr + addr_step;
            end
        end
    end

    // status read beats a same-cycle set
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vblank_flag <= 1'b0;
        end else if (status_rd) begin
            vblank_flag <= 1'b0;
        end else if (dot.vblank_set) begin
            vblank_flag <= 1'b1;
        end else if (dot.vblank_clr) begin
            vblank_flag <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            resp_valid <= 1'b0;
        end else if (rd_accept) begin
            resp_valid <= 1'b1;
        end else if (resp_ready) begin
            resp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_accept) begin
            resp_rdata <= rd_data;
        end
    end

    assign nmi       = vblank_flag && ppuctrl[CTRL_NMI_BIT];
    assign mask_grey = ppumask[MASK_GREY_BIT];

endmodule

// File: src/palette_ram.sv
`timescale 1ns/10ps

module palette_ram import ppu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    pal_if.target    pal,
    input  pal_idx_t render_addr,
    output colour_t  render_colour
);

    colour_t mem [32];

    // sprite backdrops 0x10/14/18/1C alias the background ones
    function automatic pal_idx_t fold(input pal_idx_t idx);
        pal_idx_t res;
        res = idx;
        if (idx[4] && (idx[1:0] == 2'b00)) begin
            res[4] = 1'b0;
        end
        return res;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                mem[i] <= '0;
            end
        end else if (pal.we) begin
            mem[fold(pal.addr)] <= pal.wdata;
        end
    end

    // both read ports are asynchronous
    assign pal.rdata     = mem[fold(pal.addr)];
    assign render_colour = mem[fold(render_addr)];

endmodule

// File: src/pixel_out.sv
`timescale 1ns/10ps

module pixel_out import ppu_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    dot_if.raster   dot,
    input  logic    mask_grey,
    input  colour_t backdrop,
    output logic    pix_valid,
    output colour_t pix_colour
);

    // greyscale drops the hue nibble, keeps luma
    localparam colour_t GREY_MASK = 6'h30;

    colour_t shaded;

    assign shaded = mask_grey ? (backdrop & GREY_MASK) : backdrop;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pix_valid <= 1'b0;
        end else begin
            pix_valid <= dot.visible;
        end
    end

    // colour only loads on visible dots
    always_ff @(posedge clk) begin
        if (dot.visible) begin
            pix_colour <= shaded;
        end
    end

endmodule

// File: src/ppu_top.sv
`timescale 1ns/10ps

module ppu_top import ppu_pkg::*; #(
    parameter int DOTS_PER_LINE   = DEF_DOTS_PER_LINE,
    parameter int LINES_PER_FRAME = DEF_LINES_PER_FRAME,
    parameter int VISIBLE_DOTS    = DEF_VISIBLE_DOTS,
    parameter int VISIBLE_LINES   = DEF_VISIBLE_LINES
) (
    input  logic       clk,
    input  logic       rst_n,

    input  logic       req_valid,
    output logic       req_ready,
    input  logic       req_write,
    input  reg_sel_t   req_sel,
    input  logic [7:0] req_wdata,

    output logic       resp_valid,
    input  logic       resp_ready,
    output logic [7:0] resp_rdata,

    output logic       nmi,

    output logic       pix_valid,
    output colour_t    pix_colour
);

    // only the universal backdrop is rendered
    localparam pal_idx_t BACKDROP_IDX = 5'h00;

    logic    mask_grey;
    colour_t backdrop;

    dot_if dot_bus ();
    pal_if pal_bus ();

    ppu_timing #(
        .DOTS_PER_LINE   (DOTS_PER_LINE),
        .LINES_PER_FRAME (LINES_PER_FRAME),
        .VISIBLE_DOTS    (VISIBLE_DOTS),
        .VISIBLE_LINES   (VISIBLE_LINES)
    ) ppu_timing_i (
        .clk   (clk),
        .rst_n (rst_n),
        .dot   (dot_bus.timing)
    );

    ppu_regs ppu_regs_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req_write  (req_write),
        .req_sel    (req_sel),
        .req_wdata  (req_wdata),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp_rdata (resp_rdata),
        .resp_ready (resp_ready),
        .nmi        (nmi),
        .mask_grey  (mask_grey),
        .dot        (dot_bus.events),
        .pal        (pal_bus.master)
    );

    palette_ram palette_ram_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .pal           (pal_bus.target),
        .render_addr   (BACKDROP_IDX),
        .render_colour (backdrop)
    );

    pixel_out pixel_out_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .dot        (dot_bus.raster),
        .mask_grey  (mask_grey),
        .backdrop   (backdrop),
        .pix_valid  (pix_valid),
        .pix_colour (pix_colour)
    );

endmodule

// File: tb/tb_clock.sv
`timescale 1ns/10ps

module tb_clock #(
    parameter int HALF_PERIOD  = 50,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // release on a rising edge after the reset cycles
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// File: tb/ppu_tb.sv
`timescale 1ns/10ps

module ppu_tb import ppu_pkg::*; ();

    localparam int DOTS          = 40;
    localparam int LINES         = 12;
    localparam int VIS_DOTS      = 16;
    localparam int VIS_LINES     = 6;
    localparam int REQ_TIMEOUT   = 200;
    localparam int FRAME_TIMEOUT = 3 * DOTS * LINES;

    logic       clk;
    logic       rst_n;
    logic       req_valid;
    logic       req_ready;
    logic       req_write;
    reg_sel_t   req_sel;
    logic [7:0] req_wdata;
    logic       resp_valid;
    logic       resp_ready;
    logic [7:0] resp_rdata;
    logic       nmi;
    logic       pix_valid;
    colour_t    pix_colour;
    logic       hold_off;

    // reference model state
    logic [7:0]  m_ctrl;
    logic [7:0]  m_mask;
    logic [13:0] m_addr;
    logic        m_toggle;
    logic        m_vblank;
    colour_t     m_pal [32];
    int          m_x;
    int          m_y;
    logic        exp_resp_valid;
    logic [7:0]  exp_rdata;
    logic        exp_pix_valid;
    colour_t     exp_pix_colour;
    logic        first_pixel_seen;
    int          edges;
    int          pix_count;
    int          frames_done;
    int          reads;
    int          responses;
    int          errors;

    tb_clock clock_gen_i (.clk(clk), .rst_n(rst_n));

    ppu_top #(
        .DOTS_PER_LINE   (DOTS),
        .LINES_PER_FRAME (LINES),
        .VISIBLE_DOTS    (VIS_DOTS),
        .VISIBLE_LINES   (VIS_LINES)
    ) ppu_top_i (
        .clk(clk), .rst_n(rst_n),
        .req_valid(req_valid), .req_ready(req_ready), .req_write(req_write),
        .req_sel(req_sel), .req_wdata(req_wdata),
        .resp_valid(resp_valid), .resp_ready(resp_ready), .resp_rdata(resp_rdata),
        .nmi(nmi), .pix_valid(pix_valid), .pix_colour(pix_colour)
    );

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        errors++;
        $display("mismatch %s: got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    endtask

    task automatic print_counts();
        $display("errors %0d, reads %0d, responses %0d, frames %0d",
                 errors, reads, responses, frames_done);
    endtask

    task automatic stop_on_timeout(input string what);
        errors++;
        $display("timeout while waiting for %s", what);
        print_counts();
        $display("Regression failed");
        $finish;
    endtask

    // palette writes land on both halves of a mirrored pair
    task automatic write_palette(input logic [4:0] idx, input colour_t c);
        m_pal[idx] = c;
        if (idx[1:0] == 2'b00) m_pal[idx ^ 5'h10] = c;
    endtask

    function automatic logic [7:0] expected_read(input reg_sel_t sel);
        logic [7:0] value;
        value = 8'h00;
        if (sel == REG_STATUS) value = {m_vblank, 7'h00};
        if (sel == REG_DATA && m_addr >= PAL_BASE) value = {2'b00, m_pal[m_addr[4:0]]};
        return value;
    endfunction

    task automatic apply_access(input logic wr, input reg_sel_t sel, input logic [7:0] data);
        if (wr && sel == REG_CTRL) m_ctrl = data;
        if (wr && sel == REG_MASK) m_mask = data;
        if (wr && sel == REG_ADDR) begin
            m_addr = m_toggle ? {m_addr[13:8], data} : {data[5:0], m_addr[7:0]};
            m_toggle = !m_toggle;
        end
        if (wr && sel == REG_DATA && m_addr >= PAL_BASE) write_palette(m_addr[4:0], data[5:0]);
        if (!wr && sel == REG_STATUS) m_toggle = 1'b0;
        if (sel == REG_DATA) m_addr = m_addr + (m_ctrl[CTRL_INC32_BIT] ? 14'd32 : 14'd1);
    endtask

    // compares pre-edge outputs, then steps the model through this edge
    always @(posedge clk) begin
        if (rst_n) begin
            if (m_x == 0 && m_y == 0 && edges > 0) begin
                if (pix_count != VIS_DOTS * VIS_LINES)
                    report_mismatch("pixels per frame", 32'(pix_count), 32'(VIS_DOTS * VIS_LINES));
                frames_done++;
                pix_count = 0;
            end
            if (pix_valid !== exp_pix_valid)
                report_mismatch("pix_valid", 32'(pix_valid), 32'(exp_pix_valid));
            if (pix_valid) begin
                pix_count++;
                if (pix_colour !== exp_pix_colour)
                    report_mismatch("pix_colour", 32'(pix_colour), 32'(exp_pix_colour));
                if (!first_pixel_seen && edges != 1) begin
                    errors++;
                    $display("first pixel came %0d cycles after the first dot", edges);
                end
                first_pixel_seen = 1'b1;
            end
            if (nmi !== (m_vblank && m_ctrl[CTRL_NMI_BIT]))
                report_mismatch("nmi", 32'(nmi), 32'(m_vblank && m_ctrl[CTRL_NMI_BIT]));
            if (req_ready !== !(exp_resp_valid && !resp_ready))
                report_mismatch("req_ready", 32'(req_ready),
                                32'(!(exp_resp_valid && !resp_ready)));
            if (resp_valid !== exp_resp_valid)
                report_mismatch("resp_valid", 32'(resp_valid), 32'(exp_resp_valid));
            if (resp_valid && resp_rdata !== exp_rdata)
                report_mismatch("resp_rdata", 32'(resp_rdata), 32'(exp_rdata));
            if (resp_valid && resp_ready) responses++;
            exp_pix_valid = (m_x < VIS_DOTS) && (m_y < VIS_LINES);
            if (exp_pix_valid) begin
                exp_pix_colour = m_mask[MASK_GREY_BIT] ? {m_pal[0][5:4], 4'h0} : m_pal[0];
            end
            if (req_valid && req_ready && !req_write) begin
                reads++;
                exp_rdata = expected_read(req_sel);
                exp_resp_valid = 1'b1;
            end else if (resp_ready) begin
                exp_resp_valid = 1'b0;
            end
            // status read wins over a same-cycle set
            if (req_valid && req_ready && !req_write && req_sel == REG_STATUS) m_vblank = 1'b0;
            else if (m_y == VIS_LINES + 1 && m_x == 1) m_vblank = 1'b1;
            else if (m_y == LINES - 1 && m_x == 1) m_vblank = 1'b0;
            if (req_valid && req_ready) apply_access(req_write, req_sel, req_wdata);
            if (m_x == DOTS - 1) begin
                m_x = 0;
                m_y = (m_y == LINES - 1) ? 0 : m_y + 1;
            end else begin
                m_x++;
            end
            edges++;
        end
    end

    // random back-pressure on the response channel
    always @(posedge clk) begin
        resp_ready <= hold_off ? 1'b0 : (($urandom % 4) != 0);
    end

    task automatic drive_req(input logic wr, input reg_sel_t sel, input logic [7:0] data);
        req_valid <= 1'b1;
        req_write <= wr;
        req_sel   <= sel;
        req_wdata <= data;
    endtask

    task automatic wait_accept();
        int waited;
        waited = 0;
        @(posedge clk);
        while (!req_ready && waited < REQ_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (!req_ready) stop_on_timeout("request acceptance");
        req_valid <= 1'b0;
    endtask

    task automatic send_req(input logic wr, input reg_sel_t sel, input logic [7:0] data);
        drive_req(wr, sel, data);
        wait_accept();
    endtask

    // no response pending, and with stalled set resp_ready also low
    task automatic wait_quiet(input logic stalled);
        int waited;
        waited = 0;
        @(posedge clk);
        while ((resp_valid || (stalled && resp_ready)) && waited < REQ_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (resp_valid || (stalled && resp_ready)) stop_on_timeout("an idle response channel");
    endtask

    task automatic wait_nmi(input logic level);
        int waited;
        waited = 0;
        while (nmi !== level && waited < FRAME_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (nmi !== level) stop_on_timeout("nmi");
    endtask

    task automatic wait_frames(input int count);
        int waited;
        int target;
        waited = 0;
        target = frames_done + count;
        while (frames_done < target && waited < count * FRAME_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (frames_done < target) stop_on_timeout("frame ends");
    endtask

    task automatic random_palette_traffic(input int count);
        int op;
        for (int i = 0; i < count; i++) begin
            op = $urandom % 8;
            if (op < 2) begin
                if ($urandom % 4 == 0) send_req(1'b0, REG_STATUS, 8'h00);
                // mostly palette space, sometimes below it
                send_req(1'b1, REG_ADDR, ($urandom % 8 == 0) ? 8'($urandom % 63) : 8'h3F);
                send_req(1'b1, REG_ADDR, 8'($urandom));
            end else if (op < 4) begin
                send_req(1'b1, REG_DATA, 8'($urandom));
            end else if (op < 6) begin
                send_req(1'b0, REG_DATA, 8'h00);
            end else if (op == 6) begin
                send_req(1'b1, REG_CTRL, {5'b10000, 1'($urandom), 2'b00});
            end else begin
                send_req(1'b1, REG_MASK, {7'h00, 1'($urandom)});
            end
        end
    endtask

    initial begin
        void'($urandom(8));
        req_valid  <= 1'b0;
        req_write  <= 1'b0;
        req_sel    <= REG_CTRL;
        req_wdata  <= 8'h00;
        resp_ready <= 1'b1;
        hold_off   <= 1'b0;
        m_ctrl = 8'h00;
        m_mask = 8'h00;
        m_addr = 14'h0000;
        m_toggle = 1'b0;
        m_vblank = 1'b0;
        for (int i = 0; i < 32; i++) m_pal[i] = 6'h00;
        m_x = 0;
        m_y = 0;
        exp_resp_valid = 1'b0;
        exp_rdata = 8'h00;
        exp_pix_valid = 1'b0;
        exp_pix_colour = 6'h00;
        first_pixel_seen = 1'b0;
        edges = 0;
        pix_count = 0;
        frames_done = 0;
        reads = 0;
        responses = 0;
        errors = 0;

        @(posedge clk);
        for (int w = 0; w < REQ_TIMEOUT && !rst_n; w++) @(posedge clk);
        if (!rst_n) stop_on_timeout("reset release");
        if (req_ready !== 1'b1) report_mismatch("req_ready after reset", 32'(req_ready), 1);
        if (resp_valid !== 1'b0) report_mismatch("resp_valid after reset", 32'(resp_valid), 0);
        if (nmi !== 1'b0) report_mismatch("nmi after reset", 32'(nmi), 0);
        if (pix_valid !== 1'b0) report_mismatch("pix_valid after reset", 32'(pix_valid), 0);

        send_req(1'b1, REG_CTRL, 8'h80);
        send_req(1'b1, REG_MASK, 8'h00);
        random_palette_traffic(300);

        // one read stuck behind resp_ready low, a second one waiting
        wait_quiet(1'b0);
        hold_off <= 1'b1;
        wait_quiet(1'b1);
        send_req(1'b0, REG_DATA, 8'h00);
        drive_req(1'b0, REG_STATUS, 8'h00);
        repeat (16) @(posedge clk);
        hold_off <= 1'b0;
        wait_accept();

        // vblank flag cleared by a status read, then by the pre-render line
        wait_nmi(1'b1);
        send_req(1'b0, REG_STATUS, 8'h00);
        wait_nmi(1'b1);
        wait_nmi(1'b0);

        // backdrop through the 0x10 mirror, greyscale on then off
        send_req(1'b0, REG_STATUS, 8'h00);
        send_req(1'b1, REG_ADDR, 8'h3F);
        send_req(1'b1, REG_ADDR, 8'h10);
        send_req(1'b1, REG_DATA, 8'h2A);
        send_req(1'b1, REG_MASK, 8'h01);
        wait_frames(2);
        send_req(1'b1, REG_MASK, 8'h00);
        wait_frames(1);

        wait_quiet(1'b0);
        repeat (2) @(posedge clk);
        if (reads != responses) begin
            errors++;
            $display("%0d reads produced %0d responses", reads, responses);
        end
        print_counts();
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: all.f
src/ppu_pkg.sv
src/dot_if.sv
src/pal_if.sv
src/ppu_timing.sv
src/ppu_regs.sv
src/palette_ram.sv
src/pixel_out.sv
src/ppu_top.sv
tb/tb_clock.sv
tb/ppu_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= ppu_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_TEXT ?= Regression passed

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only when the simulator output holds the pass line
run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
